// File: design/icache_pkg.sv
/*
 * icache package
 * widths and payload types shared by the two-way instruction cache,
 * its controller, its storage array and the array interface
 */

package icache_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int addr_w     = 30;   // fetch word address
    localparam int word_w     = 32;   // one instruction
    localparam int line_words = 4;    // words per line
    localparam int thread_w   = 2;    // hardware thread id

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    // word address: offset in the low bits, then index, then tag
    typedef logic [addr_w-1:0] addr_t;

    typedef logic [word_w-1:0] word_t;

    // word 0 sits in bits 31:0
    typedef logic [line_words-1:0][word_w-1:0] line_t;

    typedef logic [thread_w-1:0] thread_t;

    typedef logic way_t;              // way0 / way1

endpackage

// File: design/icache_array_if.sv
/*
 * icache array interface
 * read, write and LRU touch signals between the cache controller
 * and the tag/data storage of both ways
 */

interface icache_array_if #(
    parameter int num_sets = 256
);

    localparam int off_w   = $clog2(icache_pkg::line_words);
    localparam int index_w = $clog2(num_sets);
    localparam int tag_w   = icache_pkg::addr_w - off_w - index_w;

    logic                       rd_en;        // synchronous read, data next cycle
    logic [index_w-1:0]         rd_index;

    logic                       wr_en;        // line fill
    logic [index_w-1:0]         wr_index;
    icache_pkg::way_t           wr_way;
    logic [tag_w-1:0]           wr_tag;
    icache_pkg::thread_t        wr_thread;
    icache_pkg::line_t          wr_line;

    logic                       touch_en;     // lru update
    logic [index_w-1:0]         touch_index;
    icache_pkg::way_t           touch_way;

    logic [1:0]                 rd_valid;     // per way, set of last read
    logic [1:0][tag_w-1:0]      rd_tag;
    icache_pkg::thread_t [1:0]  rd_thread;
    icache_pkg::line_t [1:0]    rd_line;
    icache_pkg::way_t           rd_lru;       // way to replace next

    modport ctrl_mp (
        output rd_en, rd_index,
        output wr_en, wr_index, wr_way, wr_tag, wr_thread, wr_line,
        output touch_en, touch_index, touch_way,
        input  rd_valid, rd_tag, rd_thread, rd_line, rd_lru
    );

    modport array_mp (
        input  rd_en, rd_index,
        input  wr_en, wr_index, wr_way, wr_tag, wr_thread, wr_line,
        input  touch_en, touch_index, touch_way,
        output rd_valid, rd_tag, rd_thread, rd_line, rd_lru
    );

endinterface

// File: design/icache_array.sv
/*
 * icache storage array
 * valid bits, tags, thread ids and lines of both ways plus one LRU bit
 * per set; reads are registered, fills and LRU touches land on the edge
 * of the cycle that strobes them
 */

module icache_array #(
    parameter int num_sets = 256
) (
    input  logic              clk,
    input  logic              arst_n,
    icache_array_if.array_mp  arr
);

    localparam int off_w   = $clog2(icache_pkg::line_words);
    localparam int index_w = $clog2(num_sets);
    localparam int tag_w   = icache_pkg::addr_w - off_w - index_w;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    logic [num_sets-1:0]  valid_q [2];                  // per way
    logic [num_sets-1:0]  lru_q;                        // holds the victim way

    logic [tag_w-1:0]     tag_mem    [2][num_sets];
    icache_pkg::thread_t  thread_mem [2][num_sets];
    icache_pkg::line_t    line_mem   [2][num_sets];

    logic                 touch_fwd;                    // touch hits the set being read

    assign touch_fwd = arr.touch_en && (arr.touch_index == arr.rd_index);

    ////////////////////////////////////////
    // valid and lru bits
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q[0]   <= '0;
            valid_q[1]   <= '0;
            lru_q        <= '0;
            arr.rd_valid <= '0;
            arr.rd_lru   <= '0;
        end else begin
            if (arr.wr_en) begin
                valid_q[arr.wr_way][arr.wr_index] <= 1'b1;
            end
            if (arr.touch_en) begin
                lru_q[arr.touch_index] <= ~arr.touch_way;   // other way goes next
            end
            if (arr.rd_en) begin
                arr.rd_valid <= {valid_q[1][arr.rd_index], valid_q[0][arr.rd_index]};
                // a hit touch and the next read can share a cycle
                if (touch_fwd) begin
                    arr.rd_lru <= ~arr.touch_way;
                end else begin
                    arr.rd_lru <= lru_q[arr.rd_index];
                end
            end
        end
    end

    ////////////////////////////////////////
    // tags, thread ids and lines
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (arr.wr_en) begin
            tag_mem[arr.wr_way][arr.wr_index]    <= arr.wr_tag;
            thread_mem[arr.wr_way][arr.wr_index] <= arr.wr_thread;
            line_mem[arr.wr_way][arr.wr_index]   <= arr.wr_line;
        end
        if (arr.rd_en) begin
            for (int w = 0; w < 2; w++) begin
                arr.rd_tag[w]    <= tag_mem[w][arr.rd_index];
                arr.rd_thread[w] <= thread_mem[w][arr.rd_index];
                arr.rd_line[w]   <= line_mem[w][arr.rd_index];
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // index width rounds up, so a non power of two num_sets leaves holes
    a_wr_index_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        arr.wr_en |-> (int'(arr.wr_index) < num_sets)
    ) else $error("icache_array: fill index %0d outside %0d sets", arr.wr_index, num_sets);

    a_touch_index_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        arr.touch_en |-> (int'(arr.touch_index) < num_sets)
    ) else $error("icache_array: touch index %0d outside %0d sets", arr.touch_index, num_sets);

endmodule

// File: design/icache_ctrl.sv
/*
 * icache controller
 * idle / lookup / refill FSM for one fetch at a time: thread tagged hit
 * check over both ways, victim choice, one L2 line request per miss and
 * word select for the fetch response
 */

module icache_ctrl #(
    parameter int num_sets = 256
) (
    input  logic                 clk,
    input  logic                 arst_n,
    // fetch side
    input  logic                 req,
    input  icache_pkg::addr_t    req_addr,
    input  icache_pkg::thread_t  req_thread,
    output logic                 busy,
    output logic                 rsp_valid,
    output icache_pkg::word_t    rsp_word,
    // l2 side
    output logic                 l2_req,
    output icache_pkg::addr_t    l2_req_addr,
    output icache_pkg::thread_t  l2_req_thread,
    input  logic                 l2_rdy,
    input  icache_pkg::line_t    l2_line,
    input  icache_pkg::thread_t  l2_thread,
    // storage array
    icache_array_if.ctrl_mp      arr
);

    localparam int off_w   = $clog2(icache_pkg::line_words);
    localparam int index_w = $clog2(num_sets);
    localparam int tag_w   = icache_pkg::addr_w - off_w - index_w;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_refill
    } state_t;

    state_t               state_q;
    state_t               state_d;

    icache_pkg::addr_t    addr_q;          // fetch in progress
    icache_pkg::thread_t  thread_q;
    icache_pkg::way_t     victim_q;
    icache_pkg::way_t     victim_d;
    logic                 rsp_q;           // refill response pending
    icache_pkg::word_t    rsp_word_q;

    logic [off_w-1:0]     offset_q;
    logic [index_w-1:0]   index_q;
    logic [tag_w-1:0]     tag_q;

    logic [1:0]           hit_way;
    icache_pkg::way_t     hit_idx;
    logic                 hit;
    logic                 miss;
    logic                 fill;
    logic                 accept;

    assign offset_q = addr_q[off_w-1:0];
    assign index_q  = addr_q[off_w +: index_w];
    assign tag_q    = addr_q[icache_pkg::addr_w-1 -: tag_w];

    ////////////////////////////////////////
    // hit detection and victim choice
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_way[w] = arr.rd_valid[w]
                      && (arr.rd_tag[w] == tag_q)
                      && (arr.rd_thread[w] == thread_q);   // same line, other thread misses
        end
    end

    assign hit_idx = icache_pkg::way_t'(hit_way[1]);
    assign hit     = (state_q == st_lookup) && (|hit_way);
    assign miss    = (state_q == st_lookup) && !(|hit_way);
    assign fill    = (state_q == st_refill) && l2_rdy && (l2_thread == thread_q);

    // empty way0, then empty way1, then lru
    always_comb begin
        if (!arr.rd_valid[0]) begin
            victim_d = 1'b0;
        end else if (!arr.rd_valid[1]) begin
            victim_d = 1'b1;
        end else begin
            victim_d = arr.rd_lru;
        end
    end

    ////////////////////////////////////////
    // fetch and l2 ports
    ////////////////////////////////////////

    assign busy      = miss || (state_q == st_refill);
    assign accept    = req && !busy;
    assign rsp_valid = hit || rsp_q;
    assign rsp_word  = hit ? arr.rd_line[hit_idx][offset_q] : rsp_word_q;

    assign l2_req        = miss;
    assign l2_req_addr   = {addr_q[icache_pkg::addr_w-1:off_w], {off_w{1'b0}}};   // offset cleared
    assign l2_req_thread = thread_q;

    ////////////////////////////////////////
    // array access
    ////////////////////////////////////////

    assign arr.rd_en    = accept;
    assign arr.rd_index = req_addr[off_w +: index_w];

    assign arr.wr_en     = fill;
    assign arr.wr_index  = index_q;
    assign arr.wr_way    = victim_q;
    assign arr.wr_tag    = tag_q;
    assign arr.wr_thread = thread_q;
    assign arr.wr_line   = l2_line;

    assign arr.touch_en    = hit || fill;
    assign arr.touch_index = index_q;
    assign arr.touch_way   = hit ? hit_idx : victim_q;

    ////////////////////////////////////////
    // fsm
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (accept) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                if (miss) begin
                    state_d = st_refill;
                end else if (accept) begin
                    state_d = st_lookup;   // back to back hit
                end else begin
                    state_d = st_idle;
                end
            end
            st_refill: begin
                if (fill) begin
                    state_d = st_idle;     // response goes out from rsp_q
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            rsp_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            rsp_q   <= fill;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= req_addr;
            thread_q <= req_thread;
        end
        if (miss) begin
            victim_q <= victim_d;
        end
        if (fill) begin
            rsp_word_q <= l2_line[offset_q];
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_no_req_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        req |-> !busy
    ) else $error("icache_ctrl: fetch request while busy");

    a_rsp_l2_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(rsp_valid && l2_req)
    ) else $error("icache_ctrl: response and L2 request in one cycle");

    // both ways holding the same line means a fill went to the wrong way
    a_single_hit: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state_q == st_lookup) |-> !(&hit_way)
    ) else $error("icache_ctrl: set %0d hits in both ways", index_q);

endmodule

// File: design/icache_top.sv
/*
 * icache top level
 * two-way set-associative instruction cache with thread tagged lines;
 * joins the controller and the storage array through the array interface
 */

module icache_top #(
    parameter int num_sets = 256
) (
    input  logic                 clk,
    input  logic                 arst_n,
    // fetch request and response
    input  logic                 req,
    input  icache_pkg::addr_t    req_addr,
    input  icache_pkg::thread_t  req_thread,
    output logic                 busy,
    output logic                 rsp_valid,
    output icache_pkg::word_t    rsp_word,
    // line request to l2 and its return
    output logic                 l2_req,
    output icache_pkg::addr_t    l2_req_addr,
    output icache_pkg::thread_t  l2_req_thread,
    input  logic                 l2_rdy,
    input  icache_pkg::line_t    l2_line,
    input  icache_pkg::thread_t  l2_thread
);

    icache_array_if #(.num_sets(num_sets)) arr_if ();

    icache_ctrl #(
        .num_sets(num_sets)
    ) i_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (req),
        .req_addr      (req_addr),
        .req_thread    (req_thread),
        .busy          (busy),
        .rsp_valid     (rsp_valid),
        .rsp_word      (rsp_word),
        .l2_req        (l2_req),
        .l2_req_addr   (l2_req_addr),
        .l2_req_thread (l2_req_thread),
        .l2_rdy        (l2_rdy),
        .l2_line       (l2_line),
        .l2_thread     (l2_thread),
        .arr           (arr_if.ctrl_mp)
    );

    icache_array #(
        .num_sets(num_sets)
    ) i_array (
        .clk    (clk),
        .arst_n (arst_n),
        .arr    (arr_if.array_mp)
    );

endmodule

// File: verif/icache_tb.sv
/*
 * icache testbench
 * drives icache_top with directed and LCG chosen fetches, models the L2
 * behind it and keeps a reference copy of the tag state to predict hits
 */

module icache_tb;

    localparam int num_sets       = 16;                 // small so sets alias quickly
    localparam int off_w          = $clog2(icache_pkg::line_words);
    localparam int index_w        = $clog2(num_sets);
    localparam int n_directed     = 15;
    localparam int n_random       = 200;
    localparam int timeout_cycles = (n_directed + n_random) * 20 + 100;

    logic                 clk;
    logic                 arst_n;
    logic                 req;
    icache_pkg::addr_t    req_addr;
    icache_pkg::thread_t  req_thread;
    logic                 busy;
    logic                 rsp_valid;
    icache_pkg::word_t    rsp_word;
    logic                 l2_req;
    icache_pkg::addr_t    l2_req_addr;
    icache_pkg::thread_t  l2_req_thread;
    logic                 l2_rdy;
    icache_pkg::line_t    l2_line;
    icache_pkg::thread_t  l2_thread;

    int                   err_value;
    int                   err_ctrl;
    logic [31:0]          rng;                          // lcg state

    // reference copy of the tag state
    logic                 ref_valid  [num_sets][2];
    logic [29:0]          ref_tag    [num_sets][2];
    icache_pkg::thread_t  ref_thread [num_sets][2];
    logic                 ref_lru    [num_sets];

    icache_top #(
        .num_sets(num_sets)
    ) i_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (req),
        .req_addr      (req_addr),
        .req_thread    (req_thread),
        .busy          (busy),
        .rsp_valid     (rsp_valid),
        .rsp_word      (rsp_word),
        .l2_req        (l2_req),
        .l2_req_addr   (l2_req_addr),
        .l2_req_thread (l2_req_thread),
        .l2_rdy        (l2_rdy),
        .l2_line       (l2_line),
        .l2_thread     (l2_thread)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // backing memory rule of the L2
    function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t a,
                                                   input icache_pkg::thread_t th);
        logic [31:0] w;
        w = {2'b00, a} * 32'd3;
        return w ^ {th, 30'b0};
    endfunction

    function automatic icache_pkg::line_t make_line(input icache_pkg::addr_t line_addr,
                                                    input icache_pkg::thread_t th);
        icache_pkg::line_t l;
        int                i;
        for (i = 0; i < icache_pkg::line_words; i++) begin
            l[i] = mem_word(icache_pkg::addr_t'(line_addr + i), th);
        end
        return l;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (act === exp) else begin
            err_value++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic expect_hit(input string what, input logic exp, input logic got);
        assert (got == exp) else begin
            err_ctrl++;
            $display("wrong outcome at %0t for %s: expected a %s", $time, what,
                     exp ? "hit" : "miss");
        end
    endtask

    ////////////////////////////////////////
    // one fetch, with the L2 answering a miss
    ////////////////////////////////////////

    task automatic fetch(input icache_pkg::addr_t addr, input icache_pkg::thread_t th,
                         input logic stray, output logic was_hit);
        int                   idx;
        int                   w;
        int                   k;
        int                   delay;
        logic [29:0]          tag;
        logic [1:0]           hw;
        logic                 pred_hit;
        logic                 way;
        icache_pkg::addr_t    line_addr;
        icache_pkg::thread_t  other;

        idx       = addr[off_w +: index_w];
        tag       = addr >> (off_w + index_w);
        line_addr = {addr[29:off_w], {off_w{1'b0}}};
        other     = icache_pkg::thread_t'(th + 1);
        for (w = 0; w < 2; w++) begin
            hw[w] = ref_valid[idx][w] && (ref_tag[idx][w] == tag)
                 && (ref_thread[idx][w] == th);
        end
        pred_hit = |hw;

        @(posedge clk);
        #1;
        req        = 1'b1;
        req_addr   = addr;
        req_thread = th;
        @(posedge clk);
        #1;
        req = 1'b0;
        @(negedge clk);
        was_hit = rsp_valid;                                // as seen at the DUT

        if (pred_hit) begin
            way = hw[1];
            check_val("rsp_valid", 1, rsp_valid);
            check_val("l2_req", 0, l2_req);
            check_val("busy", 0, busy);
            check_val("rsp_word", mem_word(addr, th), rsp_word);
            ref_lru[idx] = ~way;
        end else begin
            check_val("l2_req", 1, l2_req);
            check_val("rsp_valid", 0, rsp_valid);
            check_val("busy", 1, busy);
            check_val("l2_req_addr", line_addr, l2_req_addr);
            check_val("l2_req_thread", th, l2_req_thread);
            rng   = lcg_next(rng);
            delay = 1 + (rng[23:16] % 6);                   // 1 to 6 cycles
            for (k = 0; k < delay; k++) begin
                @(posedge clk);
                #1;
                if (stray && k == 0) begin                  // return for another thread
                    l2_rdy    = 1'b1;
                    l2_thread = other;
                    l2_line   = make_line(line_addr, other);
                end else begin
                    l2_rdy = 1'b0;
                end
                @(negedge clk);
                check_val("busy", 1, busy);
                check_val("rsp_valid", 0, rsp_valid);
                check_val("l2_req", 0, l2_req);
            end
            @(posedge clk);
            #1;
            l2_rdy    = 1'b1;
            l2_thread = th;
            l2_line   = make_line(line_addr, th);
            @(negedge clk);
            check_val("busy", 1, busy);
            check_val("rsp_valid", 0, rsp_valid);
            @(posedge clk);
            #1;
            l2_rdy = 1'b0;
            @(negedge clk);
            check_val("rsp_valid", 1, rsp_valid);
            check_val("busy", 0, busy);
            check_val("l2_req", 0, l2_req);
            check_val("rsp_word", mem_word(addr, th), rsp_word);

            // empty way0, then empty way1, then lru
            if (!ref_valid[idx][0]) begin
                way = 1'b0;
            end else if (!ref_valid[idx][1]) begin
                way = 1'b1;
            end else begin
                way = ref_lru[idx];
            end
            ref_valid[idx][way]  = 1'b1;
            ref_tag[idx][way]    = tag;
            ref_thread[idx][way] = th;
            ref_lru[idx]         = ~way;
        end
    endtask

    ////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////

    a_req_idle: assert property (@(posedge clk) disable iff (!arst_n) req |-> !busy)
        else begin
            err_ctrl++;
            $display("protocol error at %0t: request driven while the cache is busy", $time);
        end

    a_rsp_no_l2: assert property (@(posedge clk) disable iff (!arst_n) !(rsp_valid && l2_req))
        else begin
            err_ctrl++;
            $display("protocol error at %0t: response and L2 request together", $time);
        end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        logic                 h;
        int                   n;
        icache_pkg::addr_t    a;
        icache_pkg::thread_t  t;

        err_value  = 0;
        err_ctrl   = 0;
        rng        = 32'he763;
        arst_n     = 1'b0;
        req        = 1'b0;
        req_addr   = '0;
        req_thread = '0;
        l2_rdy     = 1'b0;
        l2_line    = '0;
        l2_thread  = '0;
        for (n = 0; n < num_sets; n++) begin
            ref_valid[n][0] = 1'b0;
            ref_valid[n][1] = 1'b0;
            ref_lru[n]      = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_val("busy", 0, busy);
        check_val("rsp_valid", 0, rsp_valid);
        check_val("l2_req", 0, l2_req);

        // all four word offsets, refill at offset 3
        fetch(30'h100, 2'd0, 1'b0, h);
        expect_hit("first fetch of 0x100", 1'b0, h);
        fetch(30'h101, 2'd0, 1'b0, h);
        expect_hit("0x101 after its line", 1'b1, h);
        fetch(30'h102, 2'd0, 1'b0, h);
        fetch(30'h103, 2'd0, 1'b0, h);
        fetch(30'h207, 2'd1, 1'b0, h);

        // thread tagging and stray L2 returns
        fetch(30'h100, 2'd2, 1'b0, h);
        expect_hit("0x100 by another thread", 1'b0, h);
        fetch(30'h014, 2'd1, 1'b1, h);
        fetch(30'h014, 2'd2, 1'b0, h);
        expect_hit("line after a stray return", 1'b0, h);
        fetch(30'h016, 2'd1, 1'b0, h);
        expect_hit("0x016 by its own thread", 1'b1, h);

        // lines A, B and C share set 3
        fetch(30'h00c, 2'd0, 1'b0, h);
        fetch(30'h04d, 2'd0, 1'b0, h);
        fetch(30'h00e, 2'd0, 1'b0, h);
        expect_hit("A again", 1'b1, h);
        fetch(30'h08f, 2'd0, 1'b0, h);
        expect_hit("C", 1'b0, h);
        fetch(30'h00d, 2'd0, 1'b0, h);
        expect_hit("A after C", 1'b1, h);
        fetch(30'h04c, 2'd0, 1'b0, h);
        expect_hit("B after C", 1'b0, h);

        // four tags over sets 6 and 7, two threads
        for (n = 0; n < n_random; n++) begin
            rng = lcg_next(rng);
            a   = icache_pkg::addr_t'((rng[17:16] << 6) | ((6 + rng[18]) << 2) | rng[20:19]);
            t   = {1'b0, rng[21]};
            fetch(a, t, rng[24:22] == 3'd0, h);
        end

        repeat (2) @(posedge clk);
        $display("value errors: %0d, control errors: %0d", err_value, err_ctrl);
        if (err_value + err_ctrl == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("value errors: %0d, control errors: %0d", err_value, err_ctrl);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: tb.f
design/icache_pkg.sv
design/icache_array_if.sv
design/icache_array.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  # design, in compile order
  - files:
      - design/icache_pkg.sv
      - design/icache_array_if.sv
      - design/icache_array.sv
      - design/icache_ctrl.sv
      - design/icache_top.sv

  # testbench
  - target: test
    files:
      - verif/icache_tb.sv
